// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_packet_merge
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/counter_bin.sv ====
// Binary FIFO pointer counter with an address field and a wrap bit
`timescale 1ns/1ps

module counter_bin #(
        parameter int WIDTH = 4,
        parameter int MAX   = 8
) (
        input  logic             axi_aclk,
        input  logic             axi_aresetn,
        input  logic             i_enable,
        output logic [WIDTH-1:0] o_curr,
        output logic [WIDTH-1:0] o_next
);

        // Address field sits below the wrap bit
        logic w_at_max;

        // Last valid address reached
        assign w_at_max = (o_curr[WIDTH-2:0] == (WIDTH-1)'(MAX - 1));

        always_comb begin
                o_next = o_curr;
                if (i_enable) begin
                        if (w_at_max) begin
                                // Address back to zero, wrap bit flips
                                o_next = {~o_curr[WIDTH-1], {(WIDTH-1){1'b0}}};
                        end else begin
                                o_next = o_curr + 1'b1;
                        end
                end
        end

        // Pointer register
        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        o_curr <= '0;
                end else begin
                        o_curr <= o_next;
                end
        end

endmodule : counter_bin

// ==== design/fifo_control.sv ====
// FIFO status block that registers full, empty and occupancy from the next pointers
`timescale 1ns/1ps

module fifo_control #(
        parameter int DEPTH  = 8,
        parameter int ADDR_W = 3
) (
        input  logic            axi_aclk,
        input  logic            axi_aresetn,
        input  logic [ADDR_W:0] i_wr_ptr_next,
        input  logic [ADDR_W:0] i_rd_ptr_next,
        output logic [ADDR_W:0] o_count,
        output logic            o_full,
        output logic            o_empty
);

        // --------------------------------------------------
        // Pointer fields
        // --------------------------------------------------
        logic [ADDR_W-1:0] w_wr_addr;
        logic [ADDR_W-1:0] w_rd_addr;
        logic              w_wr_wrap;
        logic              w_rd_wrap;
        logic [ADDR_W:0]   w_count_next;

        assign w_wr_addr = i_wr_ptr_next[ADDR_W-1:0];
        assign w_rd_addr = i_rd_ptr_next[ADDR_W-1:0];
        assign w_wr_wrap = i_wr_ptr_next[ADDR_W];
        assign w_rd_wrap = i_rd_ptr_next[ADDR_W];

        // Occupancy from address distance
        always_comb begin
                if (w_wr_wrap == w_rd_wrap) begin
                        // Same lap
                        w_count_next = {1'b0, w_wr_addr} - {1'b0, w_rd_addr};
                end else begin
                        // Writer one lap ahead, works for any depth
                        w_count_next = (ADDR_W+1)'(DEPTH) + {1'b0, w_wr_addr}
                                       - {1'b0, w_rd_addr};
                end
        end

        // --------------------------------------------------
        // Registered flags
        // --------------------------------------------------
        // Flags update on the same edge as the pointer registers
        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        o_full  <= 1'b0;
                        o_empty <= 1'b1;
                        o_count <= '0;
                end else begin
                        o_full  <= (w_wr_addr == w_rd_addr) && (w_wr_wrap != w_rd_wrap);
                        o_empty <= (i_wr_ptr_next == i_rd_ptr_next);
                        o_count <= w_count_next;
                end
        end

        // Pointer distance stays within the array
        a_count_bound : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                o_count <= (ADDR_W+1)'(DEPTH))
                else $error("fifo_control count 0x%0h above depth", o_count);

        // Flags agree with the occupancy, so never both set
        a_full_empty : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                (o_full == (o_count == (ADDR_W+1)'(DEPTH)))
                && (o_empty == (o_count == '0)))
                else $error("fifo_control full %0b empty %0b at count 0x%0h",
                            o_full, o_empty, o_count);

endmodule : fifo_control

// ==== design/gaxi_fifo_sync.sv ====
// Synchronous valid/ready beat FIFO with registered flags and combinational head read
`timescale 1ns/1ps

module gaxi_fifo_sync #(
        parameter int DEPTH = 8
) (
        input  logic             axi_aclk,
        input  logic             axi_aresetn,
        input  logic             i_wr_valid,
        output logic             o_wr_ready,
        input  merge_pkg::beat_t i_wr_beat,
        output logic             o_rd_valid,
        input  logic             i_rd_ready,
        output merge_pkg::beat_t o_rd_beat
);

        import merge_pkg::*;

        // Pointer address width
        localparam int AW = $clog2(DEPTH);

        // --------------------------------------------------
        // Local signals
        // --------------------------------------------------
        logic [AW:0]   r_wr_ptr;
        logic [AW:0]   r_rd_ptr;
        logic [AW:0]   w_wr_ptr_next;
        logic [AW:0]   w_rd_ptr_next;
        logic [AW-1:0] w_wr_addr;
        logic [AW-1:0] w_rd_addr;
        logic [AW:0]   w_count;
        logic          w_full;
        logic          w_empty;
        logic          w_write;
        logic          w_read;

        // Beat storage
        beat_t r_mem [DEPTH];

        // Handshakes on both sides
        assign w_write = i_wr_valid && o_wr_ready;
        assign w_read  = o_rd_valid && i_rd_ready;

        // Write pointer
        counter_bin #(
                .WIDTH (AW + 1),
                .MAX   (DEPTH)
        ) wr_ptr_inst (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .i_enable    (w_write),
                .o_curr      (r_wr_ptr),
                .o_next      (w_wr_ptr_next)
        );

        // Read pointer
        counter_bin #(
                .WIDTH (AW + 1),
                .MAX   (DEPTH)
        ) rd_ptr_inst (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .i_enable    (w_read),
                .o_curr      (r_rd_ptr),
                .o_next      (w_rd_ptr_next)
        );

        // Flags from next pointers so they line up with the pointer registers
        fifo_control #(
                .DEPTH  (DEPTH),
                .ADDR_W (AW)
        ) ctrl_inst (
                .axi_aclk      (axi_aclk),
                .axi_aresetn   (axi_aresetn),
                .i_wr_ptr_next (w_wr_ptr_next),
                .i_rd_ptr_next (w_rd_ptr_next),
                .o_count       (w_count),
                .o_full        (w_full),
                .o_empty       (w_empty)
        );

        assign o_wr_ready = !w_full;
        assign o_rd_valid = !w_empty;

        // --------------------------------------------------
        // Memory
        // --------------------------------------------------
        assign w_wr_addr = r_wr_ptr[AW-1:0];
        assign w_rd_addr = r_rd_ptr[AW-1:0];

        always_ff @(posedge axi_aclk) begin
                if (w_write) begin
                        r_mem[w_wr_addr] <= i_wr_beat;
                end
        end

        // Head of queue, no read latency
        assign o_rd_beat = r_mem[w_rd_addr];

        // No write slips in while full
        a_no_wr_full : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                w_write |-> !((w_wr_addr == w_rd_addr) && (r_wr_ptr[AW] != r_rd_ptr[AW])))
                else $error("gaxi_fifo_sync write while full, wr_ptr 0x%0h", r_wr_ptr);

        // No read while empty
        a_no_rd_empty : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                w_read |-> (r_rd_ptr != r_wr_ptr))
                else $error("gaxi_fifo_sync read while empty, rd_ptr 0x%0h", r_rd_ptr);

        // Occupancy follows the handshakes one edge later
        a_count_track : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                1'b1 |=> (w_count == $past(w_count) + (AW+1)'($past(w_write))
                          - (AW+1)'($past(w_read))))
                else $error("gaxi_fifo_sync count 0x%0h off from handshakes", w_count);

endmodule : gaxi_fifo_sync

// ==== design/merge_pkg.sv ====
// Shared beat, egress bus and arbiter state types for the packet merger
package merge_pkg;

        // --------------------------------------------------
        // Widths
        // --------------------------------------------------
        // Payload bits per beat
        localparam int DATA_W = 16;

        // Egress source index width for two sources
        localparam int SRC_IDX_W = 1;

        // --------------------------------------------------
        // Bus types
        // --------------------------------------------------
        // One ingress beat as stored in a source FIFO
        typedef struct packed {
                logic [DATA_W-1:0] data;
                // Marks the final beat of a packet
                logic              last;
        } beat_t;

        // Egress beat tagged with the source it came from
        typedef struct packed {
                beat_t                beat;
                logic [SRC_IDX_W-1:0] src;
        } egress_t;

        // Arbiter FSM states
        typedef enum logic {
                ARB_IDLE   = 1'b0,
                ARB_LOCKED = 1'b1
        } arb_state_t;

endpackage : merge_pkg

// ==== design/packet_merge_top.sv ====
// Packet merger top with one beat FIFO per source feeding the round-robin arbiter
`timescale 1ns/1ps

module packet_merge_top #(
        parameter int FIFO_DEPTH = 8,
        parameter int NUM_SRC    = 2
) (
        input  logic               axi_aclk,
        input  logic               axi_aresetn,
        input  logic [NUM_SRC-1:0] i_in_valid,
        output logic [NUM_SRC-1:0] o_in_ready,
        input  merge_pkg::beat_t   i_in_beat [NUM_SRC],
        output logic               o_out_valid,
        output merge_pkg::egress_t o_out,
        input  logic               i_out_ready
);

        import merge_pkg::*;

        // --------------------------------------------------
        // FIFO to arbiter wires
        // --------------------------------------------------
        logic [NUM_SRC-1:0] w_fifo_valid;
        logic [NUM_SRC-1:0] w_fifo_ready;
        beat_t              w_fifo_beat [NUM_SRC];

        // One queue per ingress channel
        for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
                gaxi_fifo_sync #(
                        .DEPTH (FIFO_DEPTH)
                ) u_fifo (
                        .axi_aclk    (axi_aclk),
                        .axi_aresetn (axi_aresetn),
                        .i_wr_valid  (i_in_valid[s]),
                        .o_wr_ready  (o_in_ready[s]),
                        .i_wr_beat   (i_in_beat[s]),
                        .o_rd_valid  (w_fifo_valid[s]),
                        .i_rd_ready  (w_fifo_ready[s]),
                        .o_rd_beat   (w_fifo_beat[s])
                );
        end

        // --------------------------------------------------
        // Shared egress
        // --------------------------------------------------
        packet_rr_arbiter #(
                .NUM_SRC (NUM_SRC)
        ) u_arbiter (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .i_req_valid (w_fifo_valid),
                .i_req_beat  (w_fifo_beat),
                .o_req_ready (w_fifo_ready),
                .o_out_valid (o_out_valid),
                .o_out       (o_out),
                .i_out_ready (i_out_ready)
        );

endmodule : packet_merge_top

// ==== design/packet_rr_arbiter.sv ====
// Round-robin packet arbiter that holds one source per packet on the egress bus
`timescale 1ns/1ps

module packet_rr_arbiter #(
        parameter int NUM_SRC = 2
) (
        input  logic               axi_aclk,
        input  logic               axi_aresetn,
        input  logic [NUM_SRC-1:0] i_req_valid,
        input  merge_pkg::beat_t   i_req_beat [NUM_SRC],
        output logic [NUM_SRC-1:0] o_req_ready,
        output logic               o_out_valid,
        output merge_pkg::egress_t o_out,
        input  logic               i_out_ready
);

        import merge_pkg::*;

        localparam int IDX_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

        arb_state_t         r_state;
        // Round-robin start point
        logic [IDX_W-1:0]   r_ptr;
        // Source holding the bus
        logic [IDX_W-1:0]   r_owner;
        logic [IDX_W-1:0]   w_pick;
        logic               w_found;
        logic [IDX_W-1:0]   w_sel;
        logic               w_active;
        logic [NUM_SRC-1:0] w_grant;
        logic               w_xfer;
        logic [IDX_W-1:0]   w_ptr_after;

        // --------------------------------------------------
        // Source search
        // --------------------------------------------------
        // First valid source at or after the pointer
        always_comb begin
                int idx;
                w_found = 1'b0;
                w_pick  = r_ptr;
                for (int k = 0; k < NUM_SRC; k++) begin
                        idx = (int'(r_ptr) + k) % NUM_SRC;
                        if (!w_found && i_req_valid[idx]) begin
                                w_found = 1'b1;
                                w_pick  = IDX_W'(idx);
                        end
                end
        end

        assign w_sel    = (r_state == ARB_LOCKED) ? r_owner : w_pick;
        assign w_active = (r_state == ARB_LOCKED) || w_found;

        always_comb begin
                for (int s = 0; s < NUM_SRC; s++) begin
                        w_grant[s] = w_active && (w_sel == IDX_W'(s));
                end
        end

        // Egress straight from the granted FIFO head
        assign o_out_valid = w_active && i_req_valid[w_sel];
        assign o_out.beat  = i_req_beat[w_sel];
        assign o_out.src   = SRC_IDX_W'(w_sel);
        assign o_req_ready = w_grant & {NUM_SRC{i_out_ready}};
        assign w_xfer      = o_out_valid && i_out_ready;

        // Next start point, source after the winner
        assign w_ptr_after = (w_sel == IDX_W'(NUM_SRC - 1)) ? '0 : w_sel + 1'b1;

        // --------------------------------------------------
        // FSM
        // --------------------------------------------------
        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        r_state <= ARB_IDLE;
                        r_ptr   <= '0;
                        r_owner <= '0;
                end else begin
                        case (r_state)
                                ARB_IDLE: begin
                                        // Stalled offer locks too, so the bus holds still
                                        if (o_out_valid && !(w_xfer && o_out.beat.last)) begin
                                                r_state <= ARB_LOCKED;
                                                r_owner <= w_sel;
                                        end else if (w_xfer) begin
                                                // Single-beat packet done
                                                r_ptr <= w_ptr_after;
                                        end
                                end
                                ARB_LOCKED: begin
                                        if (w_xfer && o_out.beat.last) begin
                                                r_state <= ARB_IDLE;
                                                r_ptr   <= w_ptr_after;
                                        end
                                end
                                default: r_state <= ARB_IDLE;
                        endcase
                end
        end

        // One source at a time on the bus, the one named in the beat
        a_grant_onehot : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                w_xfer |-> (o_req_ready == (NUM_SRC'(1) << o_out.src)))
                else $error("packet_rr_arbiter ready 0x%0h for source %0d",
                            o_req_ready, o_out.src);

        // Grant fixed until the last beat leaves
        a_grant_held : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                (r_state == ARB_LOCKED) && !(w_xfer && o_out.beat.last)
                |=> (w_grant == $past(w_grant)))
                else $error("packet_rr_arbiter grant moved to 0x%0h mid-packet", w_grant);

endmodule : packet_rr_arbiter

// ==== files.f ====
design/merge_pkg.sv
design/counter_bin.sv
design/fifo_control.sv
design/gaxi_fifo_sync.sv
design/packet_rr_arbiter.sv
design/packet_merge_top.sv
verification/tb_clock_gen.sv
verification/tb_packet_merge.sv

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and synchronous active-low reset source
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int HALF_NS    = 4,
        parameter int RST_CYCLES = 4
) (
        output logic axi_aclk,
        output logic axi_aresetn
);

        // Free-running clock
        initial begin
                axi_aclk = 1'b0;
                forever begin
                        #(HALF_NS) axi_aclk = ~axi_aclk;
                end
        end

        // Reset over the first rising edges then release on a falling edge
        initial begin
                axi_aresetn = 1'b0;
                repeat (RST_CYCLES) @(posedge axi_aclk);
                @(negedge axi_aclk);
                axi_aresetn = 1'b1;
        end

endmodule : tb_clock_gen

// ==== verification/tb_packet_merge.sv ====
// Testbench for the packet merger with per-source scoreboards and egress protocol checks
`timescale 1ns/1ps

module tb_packet_merge;

        import merge_pkg::*;

        localparam int FIFO_DEPTH   = 8;
        localparam int NUM_SRC      = 2;
        localparam int PKTS_PER_SRC = 24;
        localparam int MAX_PKT_LEN  = 4;

        logic               axi_aclk;
        logic               axi_aresetn;
        logic [NUM_SRC-1:0] i_in_valid;
        logic [NUM_SRC-1:0] o_in_ready;
        beat_t              i_in_beat [NUM_SRC];
        logic               o_out_valid;
        egress_t            o_out;
        logic               i_out_ready;

        // Packet lengths and gaps drawn once at time zero
        int seed = 32'h7758_94da;
        int pkt_len [NUM_SRC][PKTS_PER_SRC];
        bit pkt_gap [NUM_SRC][PKTS_PER_SRC];
        int total_beats;
        int cycle_limit;

        // --------------------------------------------------
        // Scoreboard state
        // --------------------------------------------------
        beat_t   exp_q [NUM_SRC][$];
        int      occ [NUM_SRC];
        logic    held_valid;
        egress_t held_out;
        logic    in_pkt;
        int      pkt_src;
        logic    at_boundary;
        int      last_win;
        int      value_errors;
        int      other_errors;
        int      beats_checked;
        int      full_seen;
        int      fair_seen;

        tb_clock_gen #(
                .HALF_NS    (4),
                .RST_CYCLES (4)
        ) i_clock_gen (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn)
        );

        packet_merge_top #(
                .FIFO_DEPTH (FIFO_DEPTH),
                .NUM_SRC    (NUM_SRC)
        ) i_packet_merge_top (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .i_in_valid  (i_in_valid),
                .o_in_ready  (o_in_ready),
                .i_in_beat   (i_in_beat),
                .o_out_valid (o_out_valid),
                .o_out       (o_out),
                .i_out_ready (i_out_ready)
        );

        // Egress idle and every ingress open right after reset
        a_reset_state : assert property (@(posedge axi_aclk)
                $rose(axi_aresetn) |-> !o_out_valid && (o_in_ready == {NUM_SRC{1'b1}}))
                else begin
                        value_errors++;
                        $display("ERROR o_out_valid 0x%0h o_in_ready 0x%0h, expected 0x0 0x%0h",
                                 o_out_valid, o_in_ready, {NUM_SRC{1'b1}});
                end

        // Stalled offer stays up
        a_stall_valid : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                o_out_valid && !i_out_ready |=> o_out_valid)
                else begin
                        value_errors++;
                        $display("ERROR o_out_valid 0x0 after a stalled offer, expected 0x1");
                end

        function automatic int count_pending();
                int n;
                n = 0;
                for (int s = 0; s < NUM_SRC; s++) begin
                        n += exp_q[s].size();
                end
                return n;
        endfunction

        // One source sends its packets, beat held until accepted
        task automatic drive_source(input int src);
                int seq;
                seq = 0;
                for (int p = 0; p < PKTS_PER_SRC; p++) begin
                        for (int b = 0; b < pkt_len[src][p]; b++) begin
                                @(negedge axi_aclk);
                                i_in_valid[src]     = 1'b1;
                                i_in_beat[src].data = {1'(src), (DATA_W-1)'(seq)};
                                i_in_beat[src].last = (b == pkt_len[src][p] - 1);
                                seq++;
                                do begin
                                        @(posedge axi_aclk);
                                end while (!o_in_ready[src]);
                        end
                        // Idle cycle between packets now and then
                        if (pkt_gap[src][p]) begin
                                @(negedge axi_aclk);
                                i_in_valid[src] = 1'b0;
                        end
                end
                @(negedge axi_aclk);
                i_in_valid[src] = 1'b0;
        endtask

        task automatic check_exercised();
                if (full_seen == 0) begin
                        other_errors++;
                        $display("No FIFO ever filled up, back-pressure was never exercised");
                end
                if (fair_seen == 0) begin
                        other_errors++;
                        $display("No packet boundary found with every source waiting");
                end
                // Nothing left inside the merger once every queue has drained
                if (o_out_valid !== 1'b0) begin
                        value_errors++;
                        $display("ERROR o_out_valid 0x%0h after drain, expected 0x0",
                                 o_out_valid);
                end
        endtask

        task automatic finish_run();
                $display("Summary: %0d beats checked, %0d value errors, %0d other errors",
                         beats_checked, value_errors, other_errors);
                if (value_errors + other_errors == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        endtask

        // --------------------------------------------------
        // Main sequence
        // --------------------------------------------------
        initial begin : main_seq
                i_in_valid  = '0;
                i_out_ready = 1'b0;
                for (int s = 0; s < NUM_SRC; s++) begin
                        i_in_beat[s] = '0;
                        occ[s]       = 0;
                end
                held_valid    = 1'b0;
                held_out      = '0;
                in_pkt        = 1'b0;
                pkt_src       = 0;
                at_boundary   = 1'b1;
                // Pointer starts at source 0, so source 0 is next in turn
                last_win      = NUM_SRC - 1;
                value_errors  = 0;
                other_errors  = 0;
                beats_checked = 0;
                full_seen     = 0;
                fair_seen     = 0;
                total_beats   = 0;
                for (int s = 0; s < NUM_SRC; s++) begin
                        for (int p = 0; p < PKTS_PER_SRC; p++) begin
                                pkt_len[s][p] = 1 + $unsigned($random(seed)) % MAX_PKT_LEN;
                                pkt_gap[s][p] = ($unsigned($random(seed)) % 3) == 0;
                                total_beats += pkt_len[s][p];
                        end
                end
                cycle_limit = 20 * total_beats + 200;
                wait (axi_aresetn === 1'b1);
                @(posedge axi_aclk);
                fork
                        drive_source(0);
                        drive_source(1);
                join
                // Drain until every accepted beat has left
                do begin
                        @(negedge axi_aclk);
                end while (count_pending() != 0);
                check_exercised();
                finish_run();
        end

        // Sink ready with long stall windows
        initial begin : sink_drive
                int win;
                int mode;
                wait (axi_aresetn === 1'b1);
                // Long stall first so both FIFOs fill
                repeat (3 * FIFO_DEPTH) @(negedge axi_aclk);
                forever begin
                        mode = $unsigned($random(seed)) % 4;
                        win  = 4 + $unsigned($random(seed)) % 20;
                        repeat (win) begin
                                @(negedge axi_aclk);
                                if (mode == 0) begin
                                        i_out_ready = 1'b0;
                                end else begin
                                        i_out_ready = ($unsigned($random(seed)) % 4) != 0;
                                end
                        end
                end
        end

        initial begin : watchdog
                int cycles;
                cycles = 0;
                wait (cycle_limit > 0);
                while (cycles < cycle_limit) begin
                        @(posedge axi_aclk);
                        cycles++;
                end
                other_errors++;
                $display("Timeout after %0d cycles with %0d beats still expected",
                         cycles, count_pending());
                finish_run();
        end

        // --------------------------------------------------
        // Scoreboard
        // --------------------------------------------------
        always @(posedge axi_aclk) begin : scoreboard
                beat_t exp_beat;
                int    src;
                logic  xfer;
                logic  all_waiting;
                if (axi_aresetn) begin
                        xfer = o_out_valid && i_out_ready;
                        // Ready drops exactly when FIFO_DEPTH beats sit unread
                        for (int s = 0; s < NUM_SRC; s++) begin
                                assert (o_in_ready[s] == (occ[s] < FIFO_DEPTH)) else begin
                                        value_errors++;
                                        $display("ERROR o_in_ready[%0d] 0x%0h, expected 0x%0h",
                                                 s, o_in_ready[s], occ[s] < FIFO_DEPTH);
                                end
                                if (occ[s] == FIFO_DEPTH) begin
                                        full_seen++;
                                end
                        end
                        // Offer frozen under stall
                        if (held_valid) begin
                                assert (o_out == held_out) else begin
                                        value_errors++;
                                        $display("ERROR o_out 0x%0h under stall, expected 0x%0h",
                                                 o_out, held_out);
                                end
                        end
                        held_valid = o_out_valid && !i_out_ready;
                        held_out   = o_out;
                        // First offer after a boundary
                        if (o_out_valid && at_boundary) begin
                                all_waiting = 1'b1;
                                for (int s = 0; s < NUM_SRC; s++) begin
                                        if (occ[s] == 0) begin
                                                all_waiting = 1'b0;
                                        end
                                end
                                if (all_waiting) begin
                                        fair_seen++;
                                        assert (int'(o_out.src) == (last_win + 1) % NUM_SRC) else begin
                                                value_errors++;
                                                $display("ERROR o_out.src 0x%0h, expected 0x%0h",
                                                         o_out.src, (last_win + 1) % NUM_SRC);
                                        end
                                end
                                last_win    = int'(o_out.src);
                                at_boundary = 1'b0;
                        end
                        if (xfer) begin
                                src = int'(o_out.src);
                                // No interleaving inside a packet
                                if (in_pkt) begin
                                        assert (src == pkt_src) else begin
                                                value_errors++;
                                                $display("ERROR o_out.src 0x%0h, expected 0x%0h",
                                                         src, pkt_src);
                                        end
                                end
                                if (exp_q[src].size() == 0) begin
                                        other_errors++;
                                        $display("Beat from source %0d with an empty queue", src);
                                end else begin
                                        exp_beat = exp_q[src].pop_front();
                                        beats_checked++;
                                        assert (o_out.beat == exp_beat) else begin
                                                value_errors++;
                                                $display("ERROR o_out.beat 0x%0h, expected 0x%0h",
                                                         o_out.beat, exp_beat);
                                        end
                                end
                                occ[src]--;
                                in_pkt      = !o_out.beat.last;
                                pkt_src     = src;
                                at_boundary = o_out.beat.last;
                        end
                        // Accepted beats join their source queue
                        for (int s = 0; s < NUM_SRC; s++) begin
                                if (i_in_valid[s] && o_in_ready[s]) begin
                                        exp_q[s].push_back(i_in_beat[s]);
                                        occ[s]++;
                                end
                        end
                end
        end

endmodule : tb_packet_merge
